//--- isa_pkg.sv
package isa_pkg;

    // instruction word fields
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  cond_t;

    // N, Z, C, V from the top nibble of the status register
    typedef logic [3:0]  flags_t;
    typedef logic [31:0] status_t;

    typedef enum logic [1:0] {
        class_none,
        class_dp,
        class_mem,
        class_branch
    } instr_class_t;

    // condition field encodings
    localparam cond_t cond_eq = 4'd0;
    localparam cond_t cond_ne = 4'd1;
    localparam cond_t cond_cs = 4'd2;
    localparam cond_t cond_cc = 4'd3;
    localparam cond_t cond_mi = 4'd4;
    localparam cond_t cond_pl = 4'd5;
    localparam cond_t cond_vs = 4'd6;
    localparam cond_t cond_vc = 4'd7;
    localparam cond_t cond_hi = 4'd8;
    localparam cond_t cond_ls = 4'd9;
    localparam cond_t cond_ge = 4'd10;
    localparam cond_t cond_lt = 4'd11;
    localparam cond_t cond_gt = 4'd12;
    localparam cond_t cond_le = 4'd13;
    localparam cond_t cond_al = 4'd14;
    localparam cond_t cond_nv = 4'd15;

    // low opcode nibble of a compare, no register write
    localparam logic [3:0] cmp_op = 4'b1010;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

    // sequencer states, one instruction is fetch .. write_back
    typedef enum logic [3:0] {
        st_reset         = 4'd0,
        st_fetch         = 4'd1,
        st_fetch_wait    = 4'd2,
        st_decode        = 4'd3,
        st_execute       = 4'd4,
        st_memory        = 4'd5,
        st_memory_wait   = 4'd6,
        st_write_back    = 4'd7,
        st_load_pc_start = 4'd8
    } state_t;

    // alu operation codes as seen by the datapath
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_orr = 3'b011,
        alu_xor = 3'b111
    } alu_op_t;

    // next pc source
    typedef enum logic [1:0] {
        pc_increment = 2'b00,
        pc_start     = 2'b01,
        pc_branch    = 2'b11
    } pc_sel_t;

endpackage

//--- instr_info_if.sv
`timescale 1ns/100ps

interface instr_info_if;

    isa_pkg::instr_class_t iclass;
    ctrl_pkg::alu_op_t     dp_alu_op;

    // operand and shift sources
    logic a_from_reg;
    logic b_from_reg;
    logic shift_by_reg;

    // register file and memory behaviour
    logic writes_rd;
    logic is_store;
    logic is_load;
    logic is_literal;

    // branch options
    logic link;
    logic branch_reg;

    modport producer (
        output iclass, dp_alu_op, a_from_reg, b_from_reg, shift_by_reg,
        output writes_rd, is_store, is_load, is_literal, link, branch_reg
    );

    modport consumer (
        input iclass, dp_alu_op, a_from_reg, b_from_reg, shift_by_reg,
        input writes_rd, is_store, is_load, is_literal, link, branch_reg
    );

endinterface

//--- cycle_sequencer.sv
`timescale 1ns/100ps

module cycle_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    output ctrl_pkg::state_t  state
);

    ctrl_pkg::state_t state_next;

    always_comb begin
        case (state)
            ctrl_pkg::st_reset:         state_next = ctrl_pkg::st_load_pc_start;
            ctrl_pkg::st_load_pc_start: state_next = ctrl_pkg::st_fetch;
            ctrl_pkg::st_fetch:         state_next = ctrl_pkg::st_fetch_wait;
            ctrl_pkg::st_fetch_wait:    state_next = ctrl_pkg::st_decode;
            ctrl_pkg::st_decode:        state_next = ctrl_pkg::st_execute;
            ctrl_pkg::st_execute:       state_next = ctrl_pkg::st_memory;
            ctrl_pkg::st_memory:        state_next = ctrl_pkg::st_memory_wait;
            ctrl_pkg::st_memory_wait:   state_next = ctrl_pkg::st_write_back;
            // loop straight back, the start-up pc load happens only once
            ctrl_pkg::st_write_back:    state_next = ctrl_pkg::st_fetch;
            default:                    state_next = ctrl_pkg::st_reset;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ctrl_pkg::st_reset;
        end else begin
            state <= state_next;
        end
    end

    // every instruction ends by going back to fetch
    wb_to_fetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == ctrl_pkg::st_write_back |=> state == ctrl_pkg::st_fetch
    ) else $error("sequencer left write back to a state other than fetch");

endmodule

//--- instr_classifier.sv
`timescale 1ns/100ps

module instr_classifier (
    input  isa_pkg::opcode_t        opcode,
    input  isa_pkg::cond_t          cond,
    instr_info_if.producer          info
);

    logic is_dp;
    logic is_mem;
    logic is_branch;

    assign is_dp     = !opcode[6] && (cond != isa_pkg::cond_nv);
    assign is_mem    = (opcode[6:5] == 2'b11) || (opcode[6:3] == 4'b1000);
    assign is_branch = (opcode[6:3] == 4'b1001);

    always_comb begin
        if (is_dp) begin
            info.iclass = isa_pkg::class_dp;
        end else if (is_mem) begin
            info.iclass = isa_pkg::class_mem;
        end else if (is_branch) begin
            info.iclass = isa_pkg::class_branch;
        end else begin
            info.iclass = isa_pkg::class_none;
        end

        // sub shows up twice, the second is the compare
        case (opcode[2:0])
            3'b000:  info.dp_alu_op = ctrl_pkg::alu_add;
            3'b001:  info.dp_alu_op = ctrl_pkg::alu_sub;
            3'b010:  info.dp_alu_op = ctrl_pkg::alu_sub;
            3'b011:  info.dp_alu_op = ctrl_pkg::alu_and;
            3'b100:  info.dp_alu_op = ctrl_pkg::alu_orr;
            3'b101:  info.dp_alu_op = ctrl_pkg::alu_xor;
            default: info.dp_alu_op = ctrl_pkg::alu_add;
        endcase

        info.a_from_reg   = opcode[3];
        info.b_from_reg   = opcode[4];
        info.shift_by_reg = opcode[5];
        info.writes_rd    = is_dp && (opcode[3:0] != isa_pkg::cmp_op);
        info.is_store     = is_mem && opcode[4];
        info.is_load      = is_mem && !opcode[4];
        // pc-relative literal load
        info.is_literal   = (opcode[6:4] == 3'b100);
        info.link         = opcode[2];
        info.branch_reg   = opcode[1];

        assert ({info.is_store, info.is_load} !== 2'b11)
            else $error("memory instruction decoded as both load and store");
    end

endmodule

//--- cond_check.sv
`timescale 1ns/100ps

module cond_check (
    input  isa_pkg::cond_t    cond,
    input  isa_pkg::status_t  status_reg,
    output logic              taken
);

    isa_pkg::flags_t flags;
    logic n, z, c, v;

    assign flags = status_reg[31:28];
    assign {n, z, c, v} = flags;

    always_comb begin
        case (cond)
            isa_pkg::cond_eq: taken = z;
            isa_pkg::cond_ne: taken = !z;
            isa_pkg::cond_cs: taken = c;
            isa_pkg::cond_cc: taken = !c;
            isa_pkg::cond_mi: taken = n;
            isa_pkg::cond_pl: taken = !n;
            isa_pkg::cond_vs: taken = v;
            isa_pkg::cond_vc: taken = !v;
            // unsigned compares
            isa_pkg::cond_hi: taken = c && !z;
            isa_pkg::cond_ls: taken = !c || z;
            // signed compares
            isa_pkg::cond_ge: taken = (n == v);
            isa_pkg::cond_lt: taken = (n != v);
            isa_pkg::cond_gt: taken = !z && (n == v);
            isa_pkg::cond_le: taken = z || (n != v);
            isa_pkg::cond_al: taken = 1'b1;
            isa_pkg::cond_nv: taken = 1'b0;
            default:          taken = 1'b0;
        endcase
    end

endmodule

//--- stage_controls.sv
`timescale 1ns/100ps

module stage_controls (
    input  ctrl_pkg::state_t    state,
    instr_info_if.consumer      info,
    input  logic                taken,
    input  logic                p,
    input  logic                u,
    input  logic                w,
    input  logic                en_status_decode,
    output logic                w_en1,
    output logic                w_en2,
    output logic                w_en_ldr,
    output logic                sel_shift,
    output logic                en_a,
    output logic                en_b,
    output logic                en_s,
    output logic                sel_a_pc,
    output logic                sel_a,
    output logic                sel_b,
    output logic                sel_branch_imme,
    output logic                sel_pre_indexed,
    output logic                en_status,
    output logic                status_rdy,
    output logic                load_ir,
    output logic                load_pc,
    output ctrl_pkg::alu_op_t   alu_op,
    output ctrl_pkg::pc_sel_t   sel_pc,
    output logic                ram_w_en2
);

    always_comb begin
        w_en1           = 1'b0;
        w_en2           = 1'b0;
        w_en_ldr        = 1'b0;
        sel_shift       = 1'b0;
        en_a            = 1'b0;
        en_b            = 1'b0;
        en_s            = 1'b0;
        sel_a_pc        = 1'b0;
        sel_a           = 1'b0;
        sel_b           = 1'b0;
        sel_branch_imme = 1'b0;
        sel_pre_indexed = 1'b0;
        en_status       = 1'b0;
        status_rdy      = 1'b0;
        load_ir         = 1'b0;
        load_pc         = 1'b0;
        alu_op          = ctrl_pkg::alu_add;
        sel_pc          = ctrl_pkg::pc_increment;
        ram_w_en2       = 1'b0;

        case (state)
            ctrl_pkg::st_load_pc_start: begin
                load_pc = 1'b1;
                sel_pc  = ctrl_pkg::pc_start;
            end
            ctrl_pkg::st_decode: begin
                load_ir = 1'b1;
            end
            // operand registers load here
            ctrl_pkg::st_execute: begin
                case (info.iclass)
                    isa_pkg::class_dp: begin
                        en_a      = info.a_from_reg;
                        en_b      = info.b_from_reg;
                        en_s      = 1'b1;
                        sel_shift = info.b_from_reg && info.shift_by_reg;
                    end
                    isa_pkg::class_mem: begin
                        en_a = 1'b1;
                        if (info.a_from_reg) begin
                            // register offset, Rm through the shifter
                            en_b      = 1'b1;
                            en_s      = 1'b1;
                            sel_shift = 1'b1;
                        end else begin
                            sel_a_pc = info.is_literal;
                        end
                    end
                    isa_pkg::class_branch: begin
                        en_b      = info.branch_reg;
                        en_s      = 1'b1;
                        sel_shift = 1'b1;
                    end
                    default: ;
                endcase
            end
            // alu result used, pc advances or branches
            ctrl_pkg::st_memory: begin
                load_pc = (info.iclass != isa_pkg::class_none);
                case (info.iclass)
                    isa_pkg::class_dp: begin
                        alu_op    = info.dp_alu_op;
                        sel_a     = !info.a_from_reg;
                        sel_b     = !info.b_from_reg;
                        en_status = en_status_decode;
                        w_en1     = info.writes_rd;
                    end
                    isa_pkg::class_mem: begin
                        alu_op          = u ? ctrl_pkg::alu_add : ctrl_pkg::alu_sub;
                        sel_b           = !info.a_from_reg;
                        // post-indexed uses the unmodified base as address
                        sel_pre_indexed = !p;
                        en_status       = en_status_decode;
                        w_en2           = !p || w;
                        ram_w_en2       = info.is_store;
                    end
                    isa_pkg::class_branch: begin
                        sel_pc          = taken ? ctrl_pkg::pc_branch : ctrl_pkg::pc_increment;
                        w_en1           = info.link;
                        sel_a           = 1'b1;
                        sel_b           = !info.branch_reg;
                        sel_branch_imme = !info.branch_reg;
                        alu_op          = ctrl_pkg::alu_add;
                    end
                    default: ;
                endcase
            end
            ctrl_pkg::st_memory_wait: begin
                status_rdy = 1'b1;
            end
            ctrl_pkg::st_write_back: begin
                w_en_ldr = info.is_load;
            end
            default: ;
        endcase

        assert (!ram_w_en2 || state == ctrl_pkg::st_memory)
            else $error("ram write outside the memory cycle");
        assert (!load_ir || state == ctrl_pkg::st_decode)
            else $error("instruction register loaded outside decode");
    end

endmodule

//--- controller.sv
`timescale 1ns/100ps

module controller (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [6:0]  opcode,
    input  logic [31:0] status_reg,
    input  logic [3:0]  cond,
    input  logic        p,
    input  logic        u,
    input  logic        w,
    input  logic        en_status_decode,
    // register file
    output logic        w_en1,
    output logic        w_en2,
    output logic        w_en_ldr,
    // operand registers and shifter
    output logic        sel_shift,
    output logic        en_a,
    output logic        en_b,
    output logic        en_s,
    output logic        sel_a_pc,
    // alu inputs
    output logic        sel_a,
    output logic        sel_b,
    output logic        sel_branch_imme,
    output logic        sel_pre_indexed,
    output logic [2:0]  alu_op,
    // status, ir, pc, ram
    output logic        en_status,
    output logic        status_rdy,
    output logic        load_ir,
    output logic        load_pc,
    output logic [1:0]  sel_pc,
    output logic        ram_w_en2
);

    ctrl_pkg::state_t  state;
    logic              taken;

    instr_info_if info_bus ();

    cycle_sequencer u_seq (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state)
    );

    instr_classifier u_class (
        .opcode (opcode),
        .cond   (cond),
        .info   (info_bus.producer)
    );

    cond_check u_cond (
        .cond       (cond),
        .status_reg (status_reg),
        .taken      (taken)
    );

    stage_controls u_ctrl (
        .state            (state),
        .info             (info_bus.consumer),
        .taken            (taken),
        .p                (p),
        .u                (u),
        .w                (w),
        .en_status_decode (en_status_decode),
        .w_en1            (w_en1),
        .w_en2            (w_en2),
        .w_en_ldr         (w_en_ldr),
        .sel_shift        (sel_shift),
        .en_a             (en_a),
        .en_b             (en_b),
        .en_s             (en_s),
        .sel_a_pc         (sel_a_pc),
        .sel_a            (sel_a),
        .sel_b            (sel_b),
        .sel_branch_imme  (sel_branch_imme),
        .sel_pre_indexed  (sel_pre_indexed),
        .en_status        (en_status),
        .status_rdy       (status_rdy),
        .load_ir          (load_ir),
        .load_pc          (load_pc),
        .alu_op           (alu_op),
        .sel_pc           (sel_pc),
        .ram_w_en2        (ram_w_en2)
    );

endmodule

//--- tb_controller.sv
`timescale 1ns/100ps

module tb_controller;

    // 113 instructions of 7 cycles plus start-up and margin
    localparam int max_cycles = 2000;

    // one field per controller output in port order
    typedef struct packed {
        logic       w_en1;
        logic       w_en2;
        logic       w_en_ldr;
        logic       sel_shift;
        logic       en_a;
        logic       en_b;
        logic       en_s;
        logic       sel_a_pc;
        logic       sel_a;
        logic       sel_b;
        logic       sel_branch_imme;
        logic       sel_pre_indexed;
        logic       en_status;
        logic       status_rdy;
        logic       load_ir;
        logic       load_pc;
        logic [2:0] alu_op;
        logic [1:0] sel_pc;
        logic       ram_w_en2;
    } strobes_t;

    logic        clk;
    logic        rst_n;
    logic [6:0]  opcode;
    logic [31:0] status_reg;
    logic [3:0]  cond;
    logic        p;
    logic        u;
    logic        w;
    logic        en_status_decode;
    logic        w_en1, w_en2, w_en_ldr, sel_shift, en_a, en_b, en_s, sel_a_pc;
    logic        sel_a, sel_b, sel_branch_imme, sel_pre_indexed, en_status;
    logic        status_rdy, load_ir, load_pc, ram_w_en2;
    logic [2:0]  alu_op;
    logic [1:0]  sel_pc;

    strobes_t    obs;
    int          seed = 91;
    int          cycle_count = 0;

    controller uut (.*);

    assign obs = {w_en1, w_en2, w_en_ldr, sel_shift, en_a, en_b, en_s, sel_a_pc,
                  sel_a, sel_b, sel_branch_imme, sel_pre_indexed, en_status,
                  status_rdy, load_ir, load_pc, alu_op, sel_pc, ram_w_en2};

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [2:0] ref_alu(input logic [2:0] f);
        case (f)
            3'b001, 3'b010: return ctrl_pkg::alu_sub;
            3'b011:         return ctrl_pkg::alu_and;
            3'b100:         return ctrl_pkg::alu_orr;
            3'b101:         return ctrl_pkg::alu_xor;
            default:        return ctrl_pkg::alu_add;
        endcase
    endfunction

    // odd condition codes invert the base test of their pair
    function automatic logic cond_holds(input logic [3:0] c, input logic [3:0] nzcv);
        logic base;
        case (c[3:1])
            3'd0:    base = nzcv[2];
            3'd1:    base = nzcv[1];
            3'd2:    base = nzcv[3];
            3'd3:    base = nzcv[0];
            3'd4:    base = nzcv[1] && !nzcv[2];
            3'd5:    base = (nzcv[3] == nzcv[0]);
            3'd6:    base = !nzcv[2] && (nzcv[3] == nzcv[0]);
            default: base = 1'b1;
        endcase
        return base ^ c[0];
    endfunction

    // expected strobes in execute, memory, memory wait and write back
    task automatic predict(output strobes_t ex, output strobes_t mem,
                           output strobes_t mw, output strobes_t wb);
        logic dp;
        logic ldst;
        logic br;
        dp   = (opcode[6] == 1'b0) && (cond != isa_pkg::cond_nv);
        ldst = (opcode[6:5] == 2'b11) || (opcode[6:3] == 4'b1000);
        br   = (opcode[6:3] == 4'b1001);
        ex   = '0;
        mem  = '0;
        mw   = '0;
        wb   = '0;
        mw.status_rdy = 1'b1;
        mem.load_pc   = dp || ldst || br;
        if (dp) begin
            ex.en_a       = opcode[3];
            ex.en_b       = opcode[4];
            ex.en_s       = 1'b1;
            ex.sel_shift  = opcode[4] && opcode[5];
            mem.alu_op    = ref_alu(opcode[2:0]);
            mem.sel_a     = !opcode[3];
            mem.sel_b     = !opcode[4];
            mem.en_status = en_status_decode;
            mem.w_en1     = (opcode[3:0] != isa_pkg::cmp_op);
        end else if (ldst) begin
            ex.en_a = 1'b1;
            if (opcode[3]) begin
                ex.en_b      = 1'b1;
                ex.en_s      = 1'b1;
                ex.sel_shift = 1'b1;
            end else begin
                ex.sel_a_pc = (opcode[6:4] == 3'b100);
            end
            mem.alu_op          = u ? ctrl_pkg::alu_add : ctrl_pkg::alu_sub;
            mem.sel_b           = !opcode[3];
            mem.sel_pre_indexed = !p;
            mem.en_status       = en_status_decode;
            mem.w_en2           = !p || w;
            mem.ram_w_en2       = opcode[4];
            wb.w_en_ldr         = !opcode[4];
        end else if (br) begin
            ex.en_b             = opcode[1];
            ex.en_s             = 1'b1;
            ex.sel_shift        = 1'b1;
            mem.sel_pc          = cond_holds(cond, status_reg[31:28]) ?
                                  ctrl_pkg::pc_branch : ctrl_pkg::pc_increment;
            mem.w_en1           = opcode[2];
            mem.sel_a           = 1'b1;
            mem.sel_b           = !opcode[1];
            mem.sel_branch_imme = !opcode[1];
            mem.alu_op          = ctrl_pkg::alu_add;
        end
    endtask

    task automatic cycles_to_load_ir(output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!load_ir);
    endtask

    task automatic run_instr(input logic [6:0] op, input logic [3:0] cnd,
                             input logic [31:0] sr, input logic pp, input logic uu,
                             input logic ww, input logic esd, input string what);
        strobes_t e_ex;
        strobes_t e_mem;
        strobes_t e_mw;
        strobes_t e_wb;
        int n;
        @(posedge clk);
        opcode           <= op;
        cond             <= cnd;
        status_reg       <= sr;
        p                <= pp;
        u                <= uu;
        w                <= ww;
        en_status_decode <= esd;
        cycles_to_load_ir(n);
        predict(e_ex, e_mem, e_mw, e_wb);
        @(negedge clk);
        check(32'(obs), 32'(e_ex), {what, " execute"});
        @(negedge clk);
        check(32'(obs), 32'(e_mem), {what, " memory"});
        @(negedge clk);
        check(32'(obs), 32'(e_mw), {what, " memory wait"});
        @(negedge clk);
        check(32'(obs), 32'(e_wb), {what, " write back"});
    endtask

    task automatic startup_sequence();
        int n;
        @(posedge clk);
        @(negedge clk);
        check(32'(load_pc), 32'd1, "start-up load_pc");
        check(32'(sel_pc), 32'(ctrl_pkg::pc_start), "start-up sel_pc");
        @(negedge clk);
        check(32'(load_pc), 32'd0, "load_pc after start-up");
        // fetch wait then decode
        cycles_to_load_ir(n);
        check(32'(n), 32'd2, "first decode after start-up");
        repeat (2) begin
            cycles_to_load_ir(n);
            check(32'(n), 32'd7, "load_ir spacing");
        end
    endtask

    task automatic data_proc_all_ops();
        logic [6:0] op;
        for (int k = 0; k < 32; k++) begin
            op = {1'b0, k[1] ^ k[3], k[4:3], k[2:0]};
            run_instr(op, 4'(k % 15), 32'h0, 1'b0, 1'b0, 1'b0, k[0] ^ k[4], "data proc");
        end
    endtask

    task automatic load_store_all_modes();
        logic [6:0] op;
        for (int form = 0; form < 5; form++) begin
            for (int k = 0; k < 8; k++) begin
                case (form)
                    0:       op = 7'b1100_000;
                    1:       op = 7'b1110_000;
                    2:       op = 7'b1101_000;
                    3:       op = 7'b1111_000;
                    // pc-relative literal load
                    default: op = 7'b1000_000;
                endcase
                op[2:0] = 3'(k);
                run_instr(op, isa_pkg::cond_al, 32'h0, k[2], k[1], k[0], k[0] ^ k[2],
                          "load/store");
            end
        end
    endtask

    task automatic branch_all_conds();
        logic [6:0]  op;
        logic [31:0] sr;
        logic        both;
        for (int i = 0; i < 40; i++) begin
            both = ((i / 16) % 2) == 0;
            op   = {4'b1001, both, both, 1'b0};
            sr   = $random(seed);
            run_instr(op, 4'(i % 16), sr, 1'b0, 1'b0, 1'b0, 1'b0, "branch");
        end
    endtask

    // bit 6 low with the never condition decodes to no class
    task automatic no_class_instr();
        run_instr(7'b0011011, isa_pkg::cond_nv, 32'hf000_0000, 1'b1, 1'b1, 1'b1, 1'b1,
                  "no class");
    endtask

    initial begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        opcode           = 7'h0;
        status_reg       = 32'h0;
        cond             = isa_pkg::cond_nv;
        p                = 1'b0;
        u                = 1'b0;
        w                = 1'b0;
        en_status_decode = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        startup_sequence();
        data_proc_all_ops();
        load_store_all_modes();
        branch_all_conds();
        no_class_instr();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- build.f
isa_pkg.sv
ctrl_pkg.sv
instr_info_if.sv
cycle_sequencer.sv
instr_classifier.sv
cond_check.sv
stage_controls.sv
controller.sv
tb_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the controller testbench with verilator, run it and check the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_controller -Mdir obj_dir -f build.f \
    && { out="$(./obj_dir/Vtb_controller)"; echo "$out"; \
         echo "$out" | grep -qx "TESTBENCH PASSED"; } \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
